// File: hw/butterfly_stage0.sv
// input memory must return in_rdata exactly one cycle after in_re; start only while ready
`timescale 1ns/1ps

module butterfly_stage0 import dct_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  logic    start,
    output logic    ready,
    output logic    in_re,
    output index_t  in_addr,
    input  sample_t in_rdata,
    output logic    wr_en,
    output logic    wr_last,
    output index_t  wr_addr,
    output sample_t wr_data
);

    logic    seq_valid, p1_valid, p2_valid, p3_valid, p3_last;
    index_t  seq_addr, p1_addr, p2_addr, p3_addr;
    sample_t p2_data0, p2_data1, p3_data;

    // idle or on the last read (addr 4)
    assign ready = !seq_valid || seq_addr == 3'd4;

    always_ff @(posedge clk) begin
        if (reset) begin
            seq_valid <= 1'b0;
            seq_addr  <= '0;
            p1_valid  <= 1'b0;
            p2_valid  <= 1'b0;
            p3_valid  <= 1'b0;
            p3_last   <= 1'b0;
        end else begin
            if (ready) begin
                seq_valid <= start;
                seq_addr  <= 3'd0;
            end else begin
                // mirrored pairs 0,7,1,6,2,5,3,4
                seq_addr <= seq_addr[2] ? index_t'(4'd8 - seq_addr) : 3'd7 - seq_addr;
            end
            p1_valid <= seq_valid;
            p2_valid <= p1_valid;
            p3_valid <= p2_valid;
            p3_last  <= p2_valid && p2_addr == 3'd4;
        end
    end

    always_ff @(posedge clk) begin
        p1_addr  <= seq_addr;
        p2_addr  <= p1_addr;
        p2_data0 <= in_rdata;
        p2_data1 <= p2_data0;
        p3_addr  <= p2_addr;
        // low half sums, high half differences
        p3_data  <= !p2_addr[2] ? p2_data0 + in_rdata : p2_data1 - p2_data0;
    end

    assign in_re   = seq_valid;
    assign in_addr = seq_addr;
    assign wr_en   = p3_valid;
    assign wr_last = p3_last;
    assign wr_addr = p3_addr;
    assign wr_data = p3_data;

    a_start_when_ready: assert property (
        @(posedge clk) disable iff (reset) start |-> ready
    );

endmodule

// File: hw/butterfly_stage1.sv
// reads its buffer for 8 cycles after block_ready; next block_ready no sooner than 8 cycles
`timescale 1ns/1ps

module butterfly_stage1 import dct_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  logic    block_ready,
    output index_t  rd_addr,
    input  sample_t rd_data,
    output logic    wr_en,
    output logic    wr_last,
    output index_t  wr_addr,
    output sample_t wr_data
);

    logic    seq_valid, p1_valid, p2_valid, p3_valid, p3_last;
    index_t  seq_addr, p1_addr, p2_addr, p3_addr;
    sample_t p1_data, p2_data0, p2_data1, p3_data;

    always_ff @(posedge clk) begin
        if (reset) begin
            seq_valid <= 1'b0;
            seq_addr  <= '0;
            p1_valid  <= 1'b0;
            p2_valid  <= 1'b0;
            p3_valid  <= 1'b0;
            p3_last   <= 1'b0;
        end else begin
            if (block_ready) begin
                seq_valid <= 1'b1;
                seq_addr  <= 3'd0;
            end else begin
                if (seq_addr == 3'd7) seq_valid <= 1'b0;
                // order 0,3,1,2,4,5,6,7
                case (seq_addr)
                    3'd0:    seq_addr <= 3'd3;
                    3'd3:    seq_addr <= 3'd1;
                    3'd1:    seq_addr <= 3'd2;
                    3'd2:    seq_addr <= 3'd4;
                    default: seq_addr <= seq_addr + 3'd1;
                endcase
            end
            p1_valid <= seq_valid;
            p2_valid <= p1_valid;
            p3_valid <= p2_valid;
            p3_last  <= p2_valid && p2_addr == 3'd7;
        end
    end

    always_ff @(posedge clk) begin
        p1_addr  <= seq_addr;
        p1_data  <= rd_data;
        p2_addr  <= p1_addr;
        p2_data0 <= p1_data;
        p2_data1 <= p2_data0;
        p3_addr  <= p2_addr;
        if (!p2_addr[2]) begin
            p3_data <= !p2_addr[1] ? p2_data0 + p1_data : p2_data1 - p2_data0;
        end else begin
            // odd path untouched here
            p3_data <= p2_data0;
        end
    end

    assign rd_addr = seq_addr;
    assign wr_en   = p3_valid;
    assign wr_last = p3_last;
    assign wr_addr = p3_addr;
    assign wr_data = p3_data;

endmodule

// File: hw/dct_pkg.sv
// Q12 fixed point at 18 bits; constants assume this Q point and sample range of about +-2.0

package dct_pkg;

    localparam int data_width = 18;
    localparam int data_q     = 12;
    localparam int n_points   = 8;

    typedef logic signed [data_width-1:0]   sample_t;
    typedef logic        [2:0]              index_t;
    typedef logic signed [2*data_width-1:0] mul_t;

    // round a 32-bit fraction constant down to the working Q point
    function automatic sample_t from_q32(input logic [33:0] v);
        return sample_t'((v + (34'd1 << (31 - data_q))) >> (32 - data_q));
    endfunction

    // --------------------------------------------------
    // rotation constants
    // --------------------------------------------------

    // cos(i*pi/16) * sqrt2
    localparam sample_t coef_r [n_points] = '{
        from_q32(34'h16a09e668),
        from_q32(34'h163150b16),
        from_q32(34'h14e7ae914),
        from_q32(34'h12d062ef9),
        from_q32(34'h100000000),
        from_q32(34'h0c9234e07),
        from_q32(34'h08a8bd3df),
        from_q32(34'h046a1577b)
    };

    // 1/sqrt2
    localparam sample_t coef_rsqrt2  = from_q32(34'h0b504f334);

    // 0.5/sqrt2, the orthonormal output scale
    localparam sample_t coef_rsqrt2h = from_q32(34'h05a82799a);

    // Q12 product, round half up
    function automatic sample_t q_mul(input sample_t a, input sample_t b);
        mul_t prod;
        prod = mul_t'(a) * mul_t'(b) + (mul_t'(1) << (data_q - 1));
        return sample_t'(prod >>> data_q);
    endfunction

endpackage

// File: hw/llm_dct8.sv
// 8-point DCT-II, memory to memory; one block may start every 8 cycles, no stall input
`timescale 1ns/1ps

module llm_dct8 import dct_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  logic    start,
    output logic    ready,
    output logic    done,
    output logic    in_re,
    output index_t  in_addr,
    input  sample_t in_rdata,
    output logic    out_we,
    output index_t  out_addr,
    output sample_t out_wdata
);

    logic    st0_wr_en, st0_wr_last, st1_wr_en, st1_wr_last, st2_wr_en, st2_wr_last;
    index_t  st0_wr_addr, st1_wr_addr, st2_wr_addr;
    index_t  st0_rd_addr, st1_rd_addr, st2_rd_addr;
    sample_t st0_wr_data, st1_wr_data, st2_wr_data;
    sample_t st0_rd_data, st1_rd_data, st2_rd_data;

    butterfly_stage0 stage0_i (
        .clk, .reset, .start, .ready, .in_re, .in_addr, .in_rdata,
        .wr_en(st0_wr_en), .wr_last(st0_wr_last), .wr_addr(st0_wr_addr), .wr_data(st0_wr_data)
    );

    pingpong_buffer buf0_i (
        .clk, .reset, .wr_en(st0_wr_en), .wr_last(st0_wr_last), .wr_addr(st0_wr_addr),
        .wr_data(st0_wr_data), .rd_addr(st0_rd_addr), .rd_data(st0_rd_data)
    );

    butterfly_stage1 stage1_i (
        .clk, .reset, .block_ready(st0_wr_en && st0_wr_last),
        .rd_addr(st0_rd_addr), .rd_data(st0_rd_data),
        .wr_en(st1_wr_en), .wr_last(st1_wr_last), .wr_addr(st1_wr_addr), .wr_data(st1_wr_data)
    );

    pingpong_buffer buf1_i (
        .clk, .reset, .wr_en(st1_wr_en), .wr_last(st1_wr_last), .wr_addr(st1_wr_addr),
        .wr_data(st1_wr_data), .rd_addr(st1_rd_addr), .rd_data(st1_rd_data)
    );

    rotation_stage2 stage2_i (
        .clk, .reset, .block_ready(st1_wr_en && st1_wr_last),
        .rd_addr(st1_rd_addr), .rd_data(st1_rd_data),
        .wr_en(st2_wr_en), .wr_last(st2_wr_last), .wr_addr(st2_wr_addr), .wr_data(st2_wr_data)
    );

    pingpong_buffer buf2_i (
        .clk, .reset, .wr_en(st2_wr_en), .wr_last(st2_wr_last), .wr_addr(st2_wr_addr),
        .wr_data(st2_wr_data), .rd_addr(st2_rd_addr), .rd_data(st2_rd_data)
    );

    output_stage3 stage3_i (
        .clk, .reset, .block_ready(st2_wr_en && st2_wr_last),
        .rd_addr(st2_rd_addr), .rd_data(st2_rd_data),
        .out_we, .out_addr, .out_wdata, .done
    );

endmodule

// File: hw/output_stage3.sv
// output memory must take every out_we as there is no back-pressure; done marks coefficient 7
`timescale 1ns/1ps

module output_stage3 import dct_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  logic    block_ready,
    output index_t  rd_addr,
    input  sample_t rd_data,
    output logic    out_we,
    output index_t  out_addr,
    output sample_t out_wdata,
    output logic    done
);

    logic    seq_valid, p10_done;
    logic    [10:1] vld;
    index_t  seq_addr, p1_addr, p2_addr, p3_addr, p4_addr, p5_addr;
    index_t  p6_addr, p7_addr, p8_addr, p9_addr, p10_addr;
    sample_t p1_data, p2_data, p3_data, p4_data, p5_data, p6_data, p7_data;
    sample_t p3_data0, p3_data1, p4_data0, p4_data1;
    sample_t p5_add, p5_sub, p6_mul, p6_sub0, p6_sub1, p7_mul0, p7_mul1;
    sample_t p8_data, p9_data, p10_data;

    always_ff @(posedge clk) begin
        if (reset) begin
            seq_valid <= 1'b0;
            seq_addr  <= '0;
            vld       <= '0;
            p10_done  <= 1'b0;
        end else begin
            if (block_ready) begin
                seq_valid <= 1'b1;
                seq_addr  <= 3'd0;
            end else begin
                if (seq_addr == 3'd6) seq_valid <= 1'b0;
                // 0,1,2,3,7,5,4,6
                case (seq_addr)
                    3'd3:    seq_addr <= 3'd7;
                    3'd7:    seq_addr <= 3'd5;
                    3'd5:    seq_addr <= 3'd4;
                    3'd4:    seq_addr <= 3'd6;
                    3'd6:    seq_addr <= 3'd0;
                    default: seq_addr <= seq_addr + 3'd1;
                endcase
            end
            vld      <= {vld[9:1], seq_valid};
            p10_done <= vld[9] && p9_addr == 3'd7;
        end
    end

    always_ff @(posedge clk) begin
        // buffer slot to coefficient index
        case (seq_addr)
            3'd1:    p1_addr <= 3'd4;
            3'd3:    p1_addr <= 3'd6;
            3'd7:    p1_addr <= 3'd5;
            3'd5:    p1_addr <= 3'd3;
            3'd4:    p1_addr <= 3'd1;
            3'd6:    p1_addr <= 3'd7;
            default: p1_addr <= seq_addr;
        endcase
        p1_data <= rd_data;
        p2_addr <= p1_addr;
        p2_data <= p1_data;

        // hold the odd pair
        p3_addr <= p2_addr;
        p3_data <= p2_data;
        if (p2_addr == 3'd5 || p2_addr == 3'd1) begin
            p3_data0 <= p2_data;
            p3_data1 <= p1_data;
        end
        p4_addr  <= p3_addr;
        p4_data  <= p3_data;
        p4_data0 <= p3_data0;
        p4_data1 <= p3_data1;

        // --------------------------------------------------
        // odd butterfly and sqrt2 scale
        // --------------------------------------------------
        p5_addr <= p4_addr;
        p5_data <= p4_data;
        p5_add  <= p4_data0 + p4_data1;
        p5_sub  <= p4_data0 - p4_data1;

        p6_addr <= p5_addr;
        p6_data <= p5_data;
        p6_mul  <= q_mul(p5_add, coef_rsqrt2);
        if (p5_addr == 3'd5) p6_sub0 <= p5_sub;
        if (p5_addr == 3'd1) p6_sub1 <= p5_sub;

        p7_addr <= p6_addr;
        p7_data <= p6_data;
        if (p6_addr == 3'd5) p7_mul0 <= p6_mul;
        if (p6_addr == 3'd1) p7_mul1 <= p6_mul;

        // merge into natural order
        p8_addr <= p7_addr;
        case (p7_addr)
            3'd5:    p8_data <= p6_sub0;
            3'd3:    p8_data <= p6_sub1;
            3'd1:    p8_data <= p7_mul1 + p7_mul0;
            3'd7:    p8_data <= p7_mul1 - p7_mul0;
            default: p8_data <= p7_data;
        endcase

        p9_addr  <= p8_addr;
        p9_data  <= p8_data;
        p10_addr <= p9_addr;
        p10_data <= q_mul(p9_data, coef_rsqrt2h);
    end

    assign rd_addr   = seq_addr;
    assign out_we    = vld[10];
    assign out_addr  = p10_addr;
    assign out_wdata = p10_data;
    assign done      = p10_done;

    // done lands on the eighth write of an unbroken burst
    a_done_on_write: assert property (
        @(posedge clk) disable iff (reset) done |-> out_we && $past(out_we, 7)
    );

endmodule

// File: hw/pingpong_buffer.sv
// one bank is read while the other fills; reader must finish within 8 cycles of a swap
`timescale 1ns/1ps

module pingpong_buffer import dct_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  logic    wr_en,
    input  logic    wr_last,
    input  index_t  wr_addr,
    input  sample_t wr_data,
    input  index_t  rd_addr,
    output sample_t rd_data
);

    sample_t mem [2*n_points];
    logic    wr_bank;
    logic    rd_bank;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[{wr_bank, wr_addr}] <= wr_data;
        end
    end

    // swap on the last word of a block
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_bank <= 1'b0;
            rd_bank <= 1'b0;
        end else if (wr_en && wr_last) begin
            rd_bank <= wr_bank;
            wr_bank <= ~wr_bank;
        end
    end

    // distributed ram, async read
    assign rd_data = mem[{rd_bank, rd_addr}];

    a_last_with_en: assert property (
        @(posedge clk) disable iff (reset) wr_last |-> wr_en
    );

endmodule

// File: hw/rotation_stage2.sv
// products rounded per term in Q12; block_ready spacing of at least 8 cycles assumed
`timescale 1ns/1ps

module rotation_stage2 import dct_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  logic    block_ready,
    output index_t  rd_addr,
    input  sample_t rd_data,
    output logic    wr_en,
    output logic    wr_last,
    output index_t  wr_addr,
    output sample_t wr_data
);

    logic    seq_valid, p6_last;
    logic    [6:1] vld;
    index_t  seq_addr, p1_addr, p2_addr, p3_addr, p4_addr, p5_addr, p6_addr;
    sample_t p1_data, p2_data;
    sample_t p3_data0, p3_data1, p3_r0, p3_r1;
    sample_t p4_data0, p4_data1, p4_r0, p4_r1;
    sample_t p5_prod0, p5_prod1, p6_data;

    always_ff @(posedge clk) begin
        if (reset) begin
            seq_valid <= 1'b0;
            seq_addr  <= 3'd1;
            vld       <= '0;
            p6_last   <= 1'b0;
        end else begin
            if (block_ready) begin
                seq_valid <= 1'b1;
                seq_addr  <= 3'd1;
            end else begin
                if (seq_addr == 3'd6) seq_valid <= 1'b0;
                // pairs (1,0) (2,3) (7,4) (5,6)
                case (seq_addr)
                    3'd1: seq_addr <= 3'd0;
                    3'd0: seq_addr <= 3'd2;
                    3'd2: seq_addr <= 3'd3;
                    3'd3: seq_addr <= 3'd7;
                    3'd7: seq_addr <= 3'd4;
                    3'd4: seq_addr <= 3'd5;
                    3'd5: seq_addr <= 3'd6;
                    3'd6: seq_addr <= 3'd1;
                endcase
            end
            vld     <= {vld[5:1], seq_valid};
            p6_last <= vld[5] && p5_addr == 3'd5;
        end
    end

    always_ff @(posedge clk) begin
        // remap read index to the result slot
        case (seq_addr)
            3'd1:    p1_addr <= 3'd0;
            3'd0:    p1_addr <= 3'd1;
            3'd7:    p1_addr <= 3'd4;
            3'd4:    p1_addr <= 3'd7;
            3'd5:    p1_addr <= 3'd6;
            3'd6:    p1_addr <= 3'd5;
            default: p1_addr <= seq_addr;
        endcase
        p1_data <= rd_data;
        p2_addr <= p1_addr;
        p2_data <= p1_data;

        // --------------------------------------------------
        // operand and coefficient select
        // --------------------------------------------------
        p3_addr <= p2_addr;
        if (!p2_addr[0]) begin
            p3_data0 <= p2_data;
            p3_data1 <= p1_data;
        end else begin
            p3_data0 <= p3_data1;
            p3_data1 <= p3_data0;
        end
        case (p2_addr)
            3'd0, 3'd1: {p3_r0, p3_r1} <= {coef_r[4], coef_r[4]};
            3'd2, 3'd3: {p3_r0, p3_r1} <= {coef_r[6], coef_r[2]};
            3'd4, 3'd7: {p3_r0, p3_r1} <= {coef_r[3], sample_t'(-coef_r[5])};
            default:    {p3_r0, p3_r1} <= {coef_r[1], coef_r[7]};
        endcase

        p4_addr  <= p3_addr;
        p4_data0 <= p3_data0;
        p4_data1 <= p3_data1;
        p4_r0    <= p3_r0;
        p4_r1    <= p3_r1;

        p5_addr  <= p4_addr;
        p5_prod0 <= q_mul(p4_data0, p4_r0);
        p5_prod1 <= q_mul(p4_data1, p4_r1);

        p6_addr  <= p5_addr;
        p6_data  <= !p5_addr[0] ? p5_prod0 + p5_prod1 : p5_prod0 - p5_prod1;
    end

    assign rd_addr = seq_addr;
    assign wr_en   = vld[6];
    assign wr_last = p6_last;
    assign wr_addr = p6_addr;
    assign wr_data = p6_data;

endmodule

// File: llm_dct8.f
+incdir+include
hw/dct_pkg.sv
hw/pingpong_buffer.sv
hw/butterfly_stage0.sv
hw/butterfly_stage1.sv
hw/rotation_stage2.sv
hw/output_stage3.sv
hw/llm_dct8.sv
tb/tb_llm_dct8.sv

// File: include/dct_ref_model.svh
// real-valued reference for testbench use only; tolerance is given in LSBs of the Q format
`ifndef DCT_REF_MODEL_SVH
`define DCT_REF_MODEL_SVH

// --------------------------------------------------
// orthonormal DCT-II, 8 points
// --------------------------------------------------

function automatic real dct_ref_coef(input real x [8], input int k);
    real acc;
    real pi;
    pi  = 3.14159265358979323846;
    acc = 0.0;
    for (int n = 0; n < 8; n++) begin
        if (k == 0) begin
            acc += x[n];
        end else begin
            acc += x[n] * $cos((2 * n + 1) * k * pi / 16.0);
        end
    end
    // dc uses 1/(2*sqrt2), the rest one half
    if (k == 0) begin
        return acc / (2.0 * $sqrt(2.0));
    end
    return acc / 2.0;
endfunction

// converts a raw fixed-point word to real
function automatic real dct_q_to_real(input longint raw, input int q);
    return real'(raw) / real'(longint'(1) << q);
endfunction

// true if the raw word lies within tol_lsb of the expected value
function automatic bit dct_coef_close(
    input real    expected,
    input longint raw,
    input int     q,
    input int     tol_lsb
);
    real err;
    err = dct_q_to_real(raw, q) - expected;
    if (err < 0.0) begin
        err = -err;
    end
    return err <= real'(tol_lsb) / real'(longint'(1) << q);
endfunction

`endif

// File: tb/tb_llm_dct8.sv
// stimulus bounded to +-2.0 in Q12; coefficients checked to 6 LSB against a real-valued model
`timescale 1ns/1ps

module tb_llm_dct8 import dct_pkg::*; ();

    `include "dct_ref_model.svh"

    localparam int n_rows         = 12;
    localparam int coef_tol       = 6;
    localparam int lcg_seed       = 73;
    localparam int drain_margin   = 200;
    localparam int timeout_cycles = n_rows * n_points + drain_margin;

    // zeros, 1.0, impulse at 0, impulse at 5, alternating 1.5, ramp
    localparam sample_t fixed_rows [6][8] = '{
        '{0, 0, 0, 0, 0, 0, 0, 0},
        '{4096, 4096, 4096, 4096, 4096, 4096, 4096, 4096},
        '{4096, 0, 0, 0, 0, 0, 0, 0},
        '{0, 0, 0, 0, 0, 4096, 0, 0},
        '{6144, -6144, 6144, -6144, 6144, -6144, 6144, -6144},
        '{-3584, -2560, -1536, -512, 512, 1536, 2560, 3584}
    };

    logic    clk = 1'b0;
    logic    reset = 1'b1;
    logic    start;
    logic    ready;
    logic    done;
    logic    in_re;
    index_t  in_addr;
    sample_t in_rdata;
    logic    out_we;
    index_t  out_addr;
    sample_t out_wdata;

    sample_t     stim [n_rows][8];
    real         exp_tab [n_rows][8];
    real         xr [8];
    logic [7:0]  rd_mask [n_rows];
    logic [7:0]  wr_mask [n_rows];
    int          rows_started = 0;
    int          reads_done = 0;
    int          reads_left = 0;
    int          wr_count = 0;
    int          cycle_count = 0;
    int          reset_cycles = 0;
    int          pend_blk = 0;
    int          blk = 0;
    logic        pend_valid = 1'b0;
    index_t      pend_addr = '0;
    int unsigned lcg_state;

    llm_dct8 llm_dct8_i (
        .clk, .reset, .start, .ready, .done, .in_re, .in_addr, .in_rdata,
        .out_we, .out_addr, .out_wdata
    );

    always #5 clk = ~clk;

    function automatic int unsigned lcg_next(input int unsigned s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_coef(input sample_t got, input real expected, input int b, input index_t k);
        if (!dct_coef_close(expected, longint'(got), data_q, coef_tol)) begin
            abort_run($sformatf("Error %0t: block %0d coefficient %0d is %0d, expected %0.2f",
                $time, b, k, got, expected * real'(1 << data_q)));
        end
    endtask

    task automatic check_flag(input logic got, input logic expected, input string what);
        if (got !== expected) begin
            abort_run($sformatf("Error %0t: %s is %b, expected %b", $time, what, got, expected));
        end
    endtask

    // --------------------------------------------------
    // table setup and end of run
    // --------------------------------------------------
    initial begin
        start     = 1'b0;
        in_rdata  = '0;
        lcg_state = lcg_seed;
        for (int r = 0; r < n_rows; r++) begin
            rd_mask[r] = '0;
            wr_mask[r] = '0;
            for (int n = 0; n < n_points; n++) begin
                if (r < 6) begin
                    stim[r][n] = fixed_rows[r][n];
                end else begin
                    lcg_state  = lcg_next(lcg_state);
                    stim[r][n] = sample_t'(int'((lcg_state >> 16) % 32'd16383) - 8191);
                end
            end
        end
        for (int r = 0; r < n_rows; r++) begin
            for (int n = 0; n < n_points; n++) begin
                xr[n] = dct_q_to_real(longint'(stim[r][n]), data_q);
            end
            for (int k = 0; k < n_points; k++) begin
                exp_tab[r][k] = dct_ref_coef(xr, k);
            end
        end
        wait (wr_count == n_rows * n_points);
        // a few idle cycles to catch stray writes
        repeat (20) @(posedge clk);
        $display("TEST PASSED");
        $finish;
    end

    // --------------------------------------------------
    // stimulus, memory models and checks
    // --------------------------------------------------
    always @(negedge clk) begin
        if (reset) begin
            reset_cycles++;
            if (reset_cycles == 8) reset = 1'b0;
        end else begin
            cycle_count++;
            if (cycle_count > timeout_cycles) begin
                abort_run($sformatf("run timed out after %0d cycles with %0d of %0d outputs written",
                    cycle_count, wr_count, n_rows * n_points));
            end
            if (rows_started == 0) begin
                check_flag(ready, 1'b1, "ready before first start");
                check_flag(out_we, 1'b0, "out_we before first start");
            end

            // input memory, data one cycle after the request
            in_rdata = pend_valid ? stim[pend_blk][pend_addr] : '0;
            check_flag(in_re, reads_left != 0, "in_re");
            pend_valid = in_re;
            if (in_re) begin
                pend_blk  = reads_done / n_points;
                pend_addr = in_addr;
                if (rd_mask[pend_blk][in_addr]) begin
                    abort_run($sformatf("block %0d read input address %0d twice", pend_blk, in_addr));
                end
                rd_mask[pend_blk][in_addr] = 1'b1;
                reads_done++;
                reads_left--;
            end

            // output capture
            check_flag(done, out_we && (wr_count % n_points == n_points - 1), "done");
            if (out_we) begin
                if (wr_count >= rows_started * n_points) begin
                    abort_run("an output was written with no block in flight");
                end
                blk = wr_count / n_points;
                if (wr_mask[blk][out_addr]) begin
                    abort_run($sformatf("block %0d wrote output address %0d twice", blk, out_addr));
                end
                wr_mask[blk][out_addr] = 1'b1;
                check_coef(out_wdata, exp_tab[blk][out_addr], blk, out_addr);
                wr_count++;
            end

            // start a row on every cycle that ready allows
            if (ready && rows_started < n_rows) begin
                start = 1'b1;
                rows_started++;
                reads_left += n_points;
            end else begin
                start = 1'b0;
            end
        end
    end

endmodule
